//--- all.f
verilog/common.sv
verilog/ps2_rx.sv
verilog/scancode_decoder.sv
verilog/key_fifo.sv
verilog/keyboard_ctrl.sv
tb/keyboard_ctrl_checker.sv
tb/keyboard_ctrl_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the keyboard controller testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module keyboard_ctrl_tb -o keyboard_ctrl_sim > build.log 2>&1 \
    && ./obj_dir/keyboard_ctrl_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; tail -n 40 build.log sim.log; exit 1; }

cat sim.log

grep -qx "TB PASSED" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

//--- tb/keyboard_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module keyboard_ctrl_tb
    import common::*;
();

    localparam int N_PLAIN = 24;
    localparam int N_MIXED = 40;
    localparam int N_BAD   = 40;

    typedef struct packed {
        byte_t code;
        logic  extended;
        logic  released;
    } key_event_t;

    logic  clk_i;
    logic  reset_i;
    logic  ps2_clk_i;
    logic  ps2_data_i;
    logic  pop_i;
    byte_t key_code_o;
    logic  key_extended_o;
    logic  key_released_o;
    logic  key_empty_o;
    logic  overflow_o;

    // reference model state
    key_event_t exp_q[$];
    logic       model_ext;
    logic       model_brk;

    logic   consume_en;
    int     test_errors;
    int     pass_count;
    int     fail_count;
    longint limit_ns;

    keyboard_ctrl i_keyboard_ctrl (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .ps2_clk_i      (ps2_clk_i),
        .ps2_data_i     (ps2_data_i),
        .pop_i          (pop_i),
        .key_code_o     (key_code_o),
        .key_extended_o (key_extended_o),
        .key_released_o (key_released_o),
        .key_empty_o    (key_empty_o),
        .overflow_o     (overflow_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #4 clk_i = ~clk_i;
        end
    end

    // returns 1 ns after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (expected !== actual) begin
            $display("** Error: %s expected 0x%h got 0x%h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("** Error: %s expected 0x%h got 0x%h", name, expected, actual);
            test_errors++;
        end
    endtask

    function automatic byte_t random_code();
        byte_t b;
        b = byte_t'($urandom);
        while (b == SC_EXTENDED || b == SC_BREAK) begin
            b = byte_t'($urandom);
        end
        return b;
    endfunction

    // set-2 prefix folding, bad frames leave everything as it is
    task automatic predict_frame(input byte_t data, input logic bad);
        key_event_t ev;
        if (!bad) begin
            if (data == SC_EXTENDED) begin
                model_ext = 1'b1;
            end else if (data == SC_BREAK) begin
                model_brk = 1'b1;
            end else begin
                ev.code     = data;
                ev.extended = model_ext;
                ev.released = model_brk;
                exp_q.push_back(ev);
                model_ext = 1'b0;
                model_brk = 1'b0;
            end
        end
    endtask

    // start, 8 data bits LSB first, odd parity, stop
    task automatic send_frame(input byte_t data, input logic bad_parity, input logic bad_stop);
        logic [10:0] bits;
        logic        parity;
        int          i;
        parity = ~(^data) ^ bad_parity;
        bits   = {~bad_stop, parity, data, 1'b0};
        predict_frame(data, bad_parity || bad_stop);
        for (i = 0; i < 11; i++) begin
            ps2_data_i = bits[i];
            wait_cycles(10);
            ps2_clk_i = 1'b0;
            wait_cycles(20);
            ps2_clk_i = 1'b1;
            wait_cycles(10);
        end
        ps2_data_i = 1'b1;
        wait_cycles(20);
    endtask

    task automatic check_head();
        key_event_t ev;
        if (exp_q.size() == 0) begin
            $display("DUT presented key code 0x%h but the model expected no event", key_code_o);
            test_errors++;
        end else begin
            ev = exp_q.pop_front();
            check_byte("key_code_o", ev.code, key_code_o);
            check_flag("key_extended_o", ev.extended, key_extended_o);
            check_flag("key_released_o", ev.released, key_released_o);
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        wait_cycles(100);
        check_flag("key_empty_o", 1'b1, key_empty_o);
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %-24s ok", name);
        end else begin
            fail_count++;
            $display("test %-24s %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // host side, pops with random gaps
    initial begin : consumer
        int gap;
        gap   = 0;
        pop_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;
            pop_i = 1'b0;
            if (consume_en && !reset_i && !key_empty_o) begin
                if (gap > 0) begin
                    gap--;
                end else begin
                    check_head();
                    pop_i = 1'b1;
                    gap   = $urandom % 6;
                end
            end
        end
    end

    initial begin : watchdog
        wait (limit_ns != 0);
        #(limit_ns);
        $display("timeout after %0d ns, the tests did not finish", limit_ns);
        $display("TB FAILED");
        $finish;
    end

    initial begin : main
        int    depth;
        int    i;
        int    r;
        byte_t b;
        void'($urandom(77101));
        reset_i     = 1'b1;
        ps2_clk_i   = 1'b1;
        ps2_data_i  = 1'b1;
        consume_en  = 1'b0;
        model_ext   = 1'b0;
        model_brk   = 1'b0;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        depth       = i_keyboard_ctrl.FIFO_DEPTH;
        // two flush codes, three overflow extras and four frames around the reset
        // each frame is 11 bits of 40 clk_i cycles
        limit_ns    = 2 * longint'(N_PLAIN + N_MIXED + N_BAD + depth + 9) * 11 * 40 * 8;
        wait_cycles(10);
        reset_i    = 1'b0;
        consume_en = 1'b1;

        for (i = 0; i < N_PLAIN; i++) begin
            send_frame(random_code(), 1'b0, 1'b0);
        end
        wait_drain();
        end_test("plain make codes");

        for (i = 0; i < N_MIXED; i++) begin
            r = $urandom % 4;
            b = (r == 0) ? SC_EXTENDED : (r == 1) ? SC_BREAK : random_code();
            send_frame(b, 1'b0, 1'b0);
        end
        send_frame(random_code(), 1'b0, 1'b0);
        wait_drain();
        end_test("prefix sequences");

        for (i = 0; i < N_BAD; i++) begin
            r = $urandom % 6;
            case (r)
                0: send_frame(byte_t'($urandom), 1'b1, 1'b0);
                1: send_frame(byte_t'($urandom), 1'b0, 1'b1);
                2: send_frame(SC_EXTENDED, 1'b0, 1'b0);
                3: send_frame(SC_BREAK, 1'b0, 1'b0);
                default: send_frame(random_code(), 1'b0, 1'b0);
            endcase
        end
        send_frame(random_code(), 1'b0, 1'b0);
        wait_drain();
        end_test("bad frames");

        // nobody pops, the last three events are dropped
        consume_en = 1'b0;
        for (i = 0; i < depth + 3; i++) begin
            send_frame(random_code(), 1'b0, 1'b0);
        end
        wait_cycles(50);
        check_flag("overflow_o", 1'b1, overflow_o);
        while (exp_q.size() > depth) begin
            exp_q.delete(exp_q.size() - 1);
        end
        consume_en = 1'b1;
        wait_drain();
        end_test("fifo overflow");

        // reset with entries queued and an extended prefix pending
        consume_en = 1'b0;
        send_frame(random_code(), 1'b0, 1'b0);
        send_frame(random_code(), 1'b0, 1'b0);
        send_frame(SC_EXTENDED, 1'b0, 1'b0);
        reset_i = 1'b1;
        wait_cycles(10);
        reset_i = 1'b0;
        exp_q.delete();
        model_ext = 1'b0;
        model_brk = 1'b0;
        wait_cycles(2);
        check_flag("key_empty_o", 1'b1, key_empty_o);
        check_flag("overflow_o", 1'b0, overflow_o);
        send_frame(random_code(), 1'b0, 1'b0);
        consume_en = 1'b1;
        wait_drain();
        end_test("reset mid-stream");

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/keyboard_ctrl_checker.sv
`timescale 1ns/1ps
`default_nettype none

module keyboard_ctrl_checker
    import common::*;
(
    input  wire logic       clk_i,
    input  wire logic       reset_i,
    input  wire logic       rx_valid_i,
    input  wire logic       dec_event_i,
    input  wire dec_state_t dec_state_i,
    input  wire logic       overflow_i,
    input  wire logic       empty_i
);

    // receiver strobe is a single cycle
    assert property (@(posedge clk_i) disable iff (reset_i) rx_valid_i |=> !rx_valid_i)
        else $error("receiver valid_o held for more than one cycle");

    // decoder write strobe is a single cycle
    assert property (@(posedge clk_i) disable iff (reset_i) dec_event_i |=> !dec_event_i)
        else $error("decoder event_o held for more than one cycle");

    // overflow is sticky
    assert property (@(posedge clk_i) (overflow_i && !reset_i) |=> overflow_i)
        else $error("overflow_o fell outside reset");

    assert property (@(posedge clk_i) reset_i |=> empty_i)
        else $error("key_empty_o low after reset");

    // pending prefixes only move on a byte from the receiver
    assert property (@(posedge clk_i) disable iff (reset_i)
        !rx_valid_i |=> $stable(dec_state_i))
        else $error("decoder state changed without a received byte");

endmodule

bind keyboard_ctrl keyboard_ctrl_checker i_keyboard_ctrl_checker (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rx_valid_i  (rx_valid),
    .dec_event_i (dec_event),
    .dec_state_i (i_scancode_decoder.state_r),
    .overflow_i  (overflow_o),
    .empty_i     (key_empty_o)
);

`default_nettype wire

//--- verilog/keyboard_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module keyboard_ctrl
    import common::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  wire logic  clk_i,
    input  wire logic  reset_i,

    // PS/2 pins, asynchronous to clk_i
    input  wire logic  ps2_clk_i,
    input  wire logic  ps2_data_i,

    // host side
    input  wire logic  pop_i,
    output      byte_t key_code_o,
    output      logic  key_extended_o,
    output      logic  key_released_o,
    output      logic  key_empty_o,
    output      logic  overflow_o
);

    byte_t rx_data;
    logic  rx_valid;
    byte_t dec_code;
    logic  dec_extended;
    logic  dec_released;
    logic  dec_event;

    ps2_rx i_ps2_rx (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .clk_ps2_async_i  (ps2_clk_i),
        .ps2_data_async_i (ps2_data_i),
        .data_o           (rx_data),
        .valid_o          (rx_valid)
    );

    scancode_decoder i_scancode_decoder (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .data_i     (rx_data),
        .valid_i    (rx_valid),
        .code_o     (dec_code),
        .extended_o (dec_extended),
        .released_o (dec_released),
        .event_o    (dec_event)
    );

    // events wait here until the host pops them
    key_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_key_fifo (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .code_i     (dec_code),
        .extended_i (dec_extended),
        .released_i (dec_released),
        .write_i    (dec_event),
        .pop_i      (pop_i),
        .code_o     (key_code_o),
        .extended_o (key_extended_o),
        .released_o (key_released_o),
        .empty_o    (key_empty_o),
        .overflow_o (overflow_o)
    );

endmodule

`default_nettype wire

//--- verilog/key_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module key_fifo
    import common::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  wire logic  clk_i,
    input  wire logic  reset_i,

    // write side, from the decoder
    input  wire byte_t code_i,
    input  wire logic  extended_i,
    input  wire logic  released_i,
    input  wire logic  write_i,

    // host side, head entry shown ahead of the pop
    input  wire logic  pop_i,
    output      byte_t code_o,
    output      logic  extended_o,
    output      logic  released_o,
    output      logic  empty_o,
    output      logic  overflow_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);

    // entry is {code, extended, released}
    logic [9:0]       mem_r [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr_r;
    logic [PTR_W-1:0] wr_ptr_r;
    logic [PTR_W:0]   count_r;
    logic             full_w;
    logic             do_pop_w;
    logic             do_write_w;

    assign empty_o = (count_r == '0);
    assign full_w  = (count_r == FULL_COUNT);

    // pop frees a slot in the same cycle, so a full fifo still accepts the write
    assign do_pop_w   = pop_i && !empty_o;
    assign do_write_w = write_i && (!full_w || do_pop_w);

    assign {code_o, extended_o, released_o} = mem_r[rd_ptr_r];

    always_ff @(posedge clk_i) begin
        if (do_write_w) begin
            mem_r[wr_ptr_r] <= {code_i, extended_i, released_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_ptr_r   <= '0;
            wr_ptr_r   <= '0;
            count_r    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_write_w) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (do_pop_w) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            if (do_write_w && !do_pop_w) begin
                count_r <= count_r + 1'b1;
            end else if (do_pop_w && !do_write_w) begin
                count_r <= count_r - 1'b1;
            end
            // sticky until reset
            if (write_i && !do_write_w) begin
                overflow_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/scancode_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module scancode_decoder
    import common::*;
(
    input  wire logic  clk_i,
    input  wire logic  reset_i,

    // bytes from the receiver
    input  wire byte_t data_i,
    input  wire logic  valid_i,

    // one key event per non-prefix byte
    output      byte_t code_o,
    output      logic  extended_o,
    output      logic  released_o,
    output      logic  event_o
);

    dec_state_t state_r;
    dec_state_t state_w;
    logic       ext_pending_w;
    logic       brk_pending_w;
    logic       is_ext_w;
    logic       is_brk_w;
    logic       is_code_w;

    // prefixes already seen for the current key
    assign ext_pending_w = (state_r == EXTENDED) || (state_r == EXT_BREAK);
    assign brk_pending_w = (state_r == BREAK) || (state_r == EXT_BREAK);

    assign is_ext_w  = valid_i && (data_i == SC_EXTENDED);
    assign is_brk_w  = valid_i && (data_i == SC_BREAK);
    assign is_code_w = valid_i && !is_ext_w && !is_brk_w;

    // a prefix adds its own flag and keeps the other one
    always_comb begin
        state_w = state_r;
        if (is_ext_w) begin
            state_w = brk_pending_w ? EXT_BREAK : EXTENDED;
        end else if (is_brk_w) begin
            state_w = ext_pending_w ? EXT_BREAK : BREAK;
        end else if (is_code_w) begin
            state_w = BASE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r <= BASE;
            event_o <= 1'b0;
        end else begin
            state_r <= state_w;
            event_o <= is_code_w;
        end
    end

    // flags are taken from the state before it returns to base
    always_ff @(posedge clk_i) begin
        if (is_code_w) begin
            code_o     <= data_i;
            extended_o <= ext_pending_w;
            released_o <= brk_pending_w;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ps2_rx.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_rx
    import common::*;
(
    input  wire logic  clk_i,
    input  wire logic  reset_i,

    // raw PS/2 lines from the keyboard
    input  wire logic  clk_ps2_async_i,
    input  wire logic  ps2_data_async_i,

    // received byte, qualified by a one cycle strobe
    output      byte_t data_o,
    output      logic  valid_o
);

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        DATA   = 2'b01,
        PARITY = 2'b10,
        STOP   = 2'b11
    } ps2_state_t;

    // clock gets two flops, data one, so data lines up with the first clock flop
    logic [1:0] ps2_clk_sync_r;
    logic       ps2_data_r;

    always_ff @(posedge clk_i) begin
        ps2_clk_sync_r <= {ps2_clk_sync_r[0], clk_ps2_async_i};
        ps2_data_r     <= ps2_data_async_i;
    end

    // keyboard drives data on the rising edge, we sample on the falling one
    logic ps2_fall_w;

    assign ps2_fall_w = ps2_clk_sync_r[1] & ~ps2_clk_sync_r[0];

    ps2_state_t state_r;
    ps2_state_t state_w;
    logic [2:0] bit_cnt_r;
    byte_t      shift_r;
    logic       parity_r;
    logic       parity_ok_w;

    // odd parity over the eight data bits plus the parity bit
    assign parity_ok_w = parity_r ^ ps2_data_r;

    always_comb begin
        state_w = state_r;
        if (ps2_fall_w) begin
            case (state_r)
                IDLE: begin
                    // low start bit opens a frame
                    if (!ps2_data_r) begin
                        state_w = DATA;
                    end
                end
                DATA: begin
                    if (bit_cnt_r == 3'd7) begin
                        state_w = PARITY;
                    end
                end
                PARITY: begin
                    // bad parity drops the frame right here
                    state_w = parity_ok_w ? STOP : IDLE;
                end
                STOP: begin
                    state_w = IDLE;
                end
                default: begin
                    state_w = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r <= IDLE;
        end else begin
            state_r <= state_w;
        end
    end

    // bit counter, parity accumulator and output strobe
    always_ff @(posedge clk_i) begin
        valid_o <= 1'b0;
        if (ps2_fall_w) begin
            case (state_r)
                IDLE: begin
                    bit_cnt_r <= 3'd0;
                    parity_r  <= 1'b0;
                end
                DATA: begin
                    bit_cnt_r <= bit_cnt_r + 3'd1;
                    parity_r  <= parity_r ^ ps2_data_r;
                end
                STOP: begin
                    // stop bit must be high, otherwise the byte is lost
                    valid_o <= ps2_data_r;
                end
                default: begin
                    bit_cnt_r <= bit_cnt_r;
                end
            endcase
        end
        if (reset_i) begin
            bit_cnt_r <= 3'd0;
            parity_r  <= 1'b0;
            valid_o   <= 1'b0;
        end
    end

    // payload, shifted in LSB first
    always_ff @(posedge clk_i) begin
        if (ps2_fall_w && state_r == DATA) begin
            shift_r <= {ps2_data_r, shift_r[7:1]};
        end
        if (ps2_fall_w && state_r == STOP && ps2_data_r) begin
            data_o <= shift_r;
        end
    end

endmodule

`default_nettype wire

//--- verilog/common.sv
`default_nettype none

package common;

    // one data byte as it comes off the PS/2 line
    typedef logic [7:0] byte_t;

    // set-2 prefix bytes
    // E0 marks the following code as an extended key
    localparam byte_t SC_EXTENDED = 8'hE0;
    // F0 marks the following code as a key release
    localparam byte_t SC_BREAK    = 8'hF0;

    // decoder state, records which prefixes are pending
    // bit 0 is the extended prefix, bit 1 the break prefix
    typedef enum logic [1:0] {
        BASE      = 2'b00,
        EXTENDED  = 2'b01,
        BREAK     = 2'b10,
        EXT_BREAK = 2'b11
    } dec_state_t;

endpackage

`default_nettype wire
